//--- project.f
logic/capture_pkg.sv
logic/mcb_pkg.sv
logic/fake_antenna.sv
logic/sample_capture.sv
logic/block_buffer.sv
logic/burst_counter.sv
logic/aq_scheduler.sv
logic/tart_capture.sv
tests/tb_tart_capture.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the capture testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

# Compile the testbench and DUT into one executable
verilator --binary --timing --assert \
   --top-module tb_tart_capture \
   -f project.f \
   -o sim_tart

# Run and keep the output
./obj_dir/sim_tart | tee "$LOG"

# Result decided by the pass line in the log
if grep -qx "STATUS: PASS" "$LOG"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

//--- tests/tb_tart_capture.sv
`timescale 1ns/100ps

module tb_tart_capture
   import capture_pkg::*, mcb_pkg::*;
();

   localparam int AXNUM        = 24;
   localparam int BLOCK_LEN    = 16;
   localparam int IW           = $clog2(BLOCK_LEN);
   localparam int NUM_BLOCKS   = 4;
   localparam int MAX_RDY_WAIT = 8;
   // Four times the worst-case drain of all blocks plus lead-in phases
   localparam int TIMEOUT_CYCLES = 4 * NUM_BLOCKS * BLOCK_LEN * (MAX_RDY_WAIT + 2) + 440;

   logic                  clk_e;
   logic                  rst_i;
   logic                  aq_ce_i;
   logic                  aq_debug_i;
   logic                  rd_req_i;
   logic                  mcb_rdy_i;
   logic [AXNUM-1:0]      ax_data_i;
   logic [AXNUM-1:0]      ax_data_o;
   logic                  mcb_ce_o;
   logic                  mcb_wr_o;
   logic [MCB_ADDR_W-1:0] mcb_adr_o;
   logic [MCB_DATA_W-1:0] mcb_dat_o;
   logic [2:0]            tart_state_o;

   // Reference model state
   logic [LFSR_W-1:0]     lfsr_m;
   logic [AXNUM-1:0]      pin_q;
   logic [AXNUM-1:0]      exp_o;
   logic                  dbg_q;
   logic [AXNUM-1:0]      cap_mem [BLOCK_LEN];
   logic [IW-1:0]         cap_ptr;
   logic [IW-1:0]         rd_ptr;
   logic [MCB_ADDR_W-1:0] exp_adr;
   logic [MCB_DATA_W-1:0] exp_dat;
   int                    cap_cnt;
   int                    acc_cnt;
   int                    blocks_done;
   int                    cycles;
   int                    seed;
   int                    rdy_wait;
   int                    path_errs;
   int                    mcb_errs;
   int                    seq_errs;

   tart_capture #(
      .AXNUM     (AXNUM),
      .BLOCK_LEN (BLOCK_LEN)
   ) tart_capture_inst (
      .clk_e        (clk_e),
      .rst_i        (rst_i),
      .aq_ce_i      (aq_ce_i),
      .aq_debug_i   (aq_debug_i),
      .rd_req_i     (rd_req_i),
      .mcb_rdy_i    (mcb_rdy_i),
      .ax_data_i    (ax_data_i),
      .ax_data_o    (ax_data_o),
      .mcb_ce_o     (mcb_ce_o),
      .mcb_wr_o     (mcb_wr_o),
      .mcb_adr_o    (mcb_adr_o),
      .mcb_dat_o    (mcb_dat_o),
      .tart_state_o (tart_state_o)
   );

   initial begin
      clk_e = 1'b0;
      forever #10 clk_e = ~clk_e;
   end

   // ----------------------------------------------------------
   // Reference models
   // ----------------------------------------------------------

   // Shift left with feedback from bits 23, 22, 21 and 16
   function automatic logic [LFSR_W-1:0] lfsr_next(input logic [LFSR_W-1:0] s);
      return {s[LFSR_W-2:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
   endfunction

   // Pin register then mux register
   always @(posedge clk_e) begin
      pin_q <= ax_data_i;
      dbg_q <= aq_debug_i;
      exp_o <= aq_debug_i ? lfsr_m[AXNUM-1:0] : pin_q;
      if (rst_i) begin
         lfsr_m <= LFSR_W'(1);
      end else if (aq_debug_i) begin
         lfsr_m <= lfsr_next(lfsr_m);
      end
   end

   // Captured block and expected MCB word stream
   always @(posedge clk_e) begin
      if (rst_i) begin
         cap_ptr     <= '0;
         cap_cnt     <= 0;
         rd_ptr      <= '0;
         acc_cnt     <= 0;
         exp_adr     <= '0;
         blocks_done <= 0;
      end else begin
         if (tart_state_o == IDLE) begin
            cap_ptr <= '0;
            cap_cnt <= 0;
         end
         if (tart_state_o == CAPTURE) begin
            cap_mem[cap_ptr] <= ax_data_o;
            cap_ptr          <= cap_ptr + IW'(1);
            cap_cnt          <= cap_cnt + 1;
            rd_ptr           <= '0;
            acc_cnt          <= 0;
         end
         // Address keeps running from one block into the next
         if (mcb_ce_o && mcb_rdy_i) begin
            rd_ptr  <= rd_ptr + IW'(1);
            acc_cnt <= acc_cnt + 1;
            exp_adr <= exp_adr + MCB_ADDR_W'(1);
            if (acc_cnt == BLOCK_LEN - 1) begin
               blocks_done <= blocks_done + 1;
            end
         end
      end
   end

   assign exp_dat = MCB_DATA_W'(cap_mem[rd_ptr]);

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------

   reset_a : assert property (@(posedge clk_e)
      rst_i |=> (tart_state_o == IDLE) && !mcb_ce_o && !mcb_wr_o)
      else begin
         seq_errs++;
         $display("FAIL reset expected state %0d ce 0 wr 0 actual state %0d ce %b wr %b",
                  IDLE, $sampled(tart_state_o), $sampled(mcb_ce_o), $sampled(mcb_wr_o));
      end

   real_path_a : assert property (@(posedge clk_e) disable iff (rst_i)
      !dbg_q |-> ax_data_o == exp_o)
      else begin
         path_errs++;
         $display("FAIL real_path expected %h actual %h", $sampled(exp_o), $sampled(ax_data_o));
      end

   fake_path_a : assert property (@(posedge clk_e) disable iff (rst_i)
      dbg_q |-> ax_data_o == exp_o)
      else begin
         path_errs++;
         $display("FAIL fake_path expected %h actual %h", $sampled(exp_o), $sampled(ax_data_o));
      end

   mcb_wr_a : assert property (@(posedge clk_e) disable iff (rst_i)
      mcb_ce_o |-> mcb_wr_o)
      else begin
         mcb_errs++;
         $display("FAIL mcb_wr expected 1 actual %b", $sampled(mcb_wr_o));
      end

   mcb_adr_a : assert property (@(posedge clk_e) disable iff (rst_i)
      mcb_ce_o |-> mcb_adr_o == exp_adr)
      else begin
         mcb_errs++;
         $display("FAIL mcb_adr expected %h actual %h", $sampled(exp_adr), $sampled(mcb_adr_o));
      end

   mcb_dat_a : assert property (@(posedge clk_e) disable iff (rst_i)
      mcb_ce_o |-> mcb_dat_o == exp_dat)
      else begin
         mcb_errs++;
         $display("FAIL mcb_dat expected %h actual %h", $sampled(exp_dat), $sampled(mcb_dat_o));
      end

   // Pending word held under back-pressure
   mcb_hold_a : assert property (@(posedge clk_e) disable iff (rst_i)
      mcb_ce_o && !mcb_rdy_i |=> mcb_ce_o && $stable(mcb_adr_o) && $stable(mcb_dat_o))
      else begin
         mcb_errs++;
         $display("MCB command dropped or changed before it was accepted");
      end

   extra_word_a : assert property (@(posedge clk_e) disable iff (rst_i)
      mcb_ce_o |-> acc_cnt < BLOCK_LEN)
      else begin
         mcb_errs++;
         $display("MCB write issued after the block was already drained");
      end

   block_words_a : assert property (@(posedge clk_e) disable iff (rst_i)
      (tart_state_o == DONE) |-> acc_cnt == BLOCK_LEN)
      else begin
         mcb_errs++;
         $display("FAIL block_words expected %0d actual %0d", BLOCK_LEN, $sampled(acc_cnt));
      end

   capture_len_a : assert property (@(posedge clk_e) disable iff (rst_i)
      (tart_state_o == CAPTURE) |-> cap_cnt < BLOCK_LEN)
      else begin
         seq_errs++;
         $display("Capture ran past one block");
      end

   capture_full_a : assert property (@(posedge clk_e) disable iff (rst_i)
      (tart_state_o == FETCH) |-> cap_cnt == BLOCK_LEN)
      else begin
         seq_errs++;
         $display("FAIL capture_full expected %0d actual %0d", BLOCK_LEN, $sampled(cap_cnt));
      end

   idle_hold_a : assert property (@(posedge clk_e) disable iff (rst_i)
      (tart_state_o == IDLE) && !aq_ce_i |=> tart_state_o == IDLE)
      else begin
         seq_errs++;
         $display("Left idle without a start strobe");
      end

   start_a : assert property (@(posedge clk_e) disable iff (rst_i)
      (tart_state_o == IDLE) && aq_ce_i |=> tart_state_o == CAPTURE)
      else begin
         seq_errs++;
         $display("Start strobe in idle did not begin a capture");
      end

   done_hold_a : assert property (@(posedge clk_e) disable iff (rst_i)
      (tart_state_o == DONE) && !rd_req_i |=> tart_state_o == DONE)
      else begin
         seq_errs++;
         $display("Left done without a read-complete strobe");
      end

   release_a : assert property (@(posedge clk_e) disable iff (rst_i)
      (tart_state_o == DONE) && rd_req_i |=> tart_state_o == IDLE)
      else begin
         seq_errs++;
         $display("Read-complete strobe in done did not return to idle");
      end

   // ----------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------

   // Random antenna bits and MCB ready
   // Ready forced high after a long wait
   initial begin
      ax_data_i = '0;
      mcb_rdy_i = 1'b0;
      seed      = 31026;
      rdy_wait  = 0;
      forever begin
         @(negedge clk_e);
         ax_data_i = AXNUM'($random(seed));
         mcb_rdy_i = 1'($random(seed));
         if (mcb_rdy_i || rdy_wait >= MAX_RDY_WAIT) begin
            mcb_rdy_i = 1'b1;
            rdy_wait  = 0;
         end else begin
            rdy_wait++;
         end
      end
   end

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk_e);
   endtask

   task automatic strobe_start;
      aq_ce_i = 1'b1;
      @(negedge clk_e);
      aq_ce_i = 1'b0;
   endtask

   task automatic strobe_read_done;
      rd_req_i = 1'b1;
      @(negedge clk_e);
      rd_req_i = 1'b0;
   endtask

   task automatic wait_for_state(input aq_state_e st);
      while (tart_state_o != st) begin
         @(negedge clk_e);
      end
   endtask

   initial begin
      rst_i      = 1'b1;
      aq_ce_i    = 1'b0;
      aq_debug_i = 1'b0;
      rd_req_i   = 1'b0;
      path_errs  = 0;
      mcb_errs   = 0;
      seq_errs   = 0;
      repeat (5) @(posedge clk_e);
      @(negedge clk_e);
      rst_i = 1'b0;

      // Real lanes only
      idle_cycles(20);
      // Fake source switched on and off
      for (int i = 0; i < 30; i++) begin
         aq_debug_i = (i % 3) != 0;
         @(negedge clk_e);
      end
      aq_debug_i = 1'b0;
      idle_cycles(4);

      // Blocks alternate real and fake data
      // Stray strobes land in every phase
      for (int b = 0; b < NUM_BLOCKS; b++) begin
         aq_debug_i = (b % 2) == 1;
         idle_cycles(2);
         strobe_start();
         strobe_start();
         wait_for_state(WRITE);
         strobe_start();
         wait_for_state(DONE);
         strobe_start();
         idle_cycles(3);
         strobe_read_done();
         strobe_read_done();
         idle_cycles(2);
      end
      aq_debug_i = 1'b0;
      idle_cycles(5);

      if (blocks_done != NUM_BLOCKS) begin
         seq_errs++;
         $display("FAIL blocks_done expected %0d actual %0d", NUM_BLOCKS, blocks_done);
      end
      $display("Errors: sample path %0d, mcb %0d, sequencing %0d", path_errs, mcb_errs,
               seq_errs);
      if (path_errs + mcb_errs + seq_errs == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Watchdog
   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk_e);
         cycles++;
      end
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- logic/tart_capture.sv
`timescale 1ns/100ps

module tart_capture
   import capture_pkg::*, mcb_pkg::*;
#(
   parameter int  AXNUM     = 24,
   parameter int  BLOCK_LEN = 16,
   localparam int IW        = $clog2(BLOCK_LEN)
) (
   input  logic                  clk_e,
   input  logic                  rst_i,
   // Host strobes
   input  logic                  aq_ce_i,
   input  logic                  aq_debug_i,
   input  logic                  rd_req_i,
   input  logic                  mcb_rdy_i,
   // Antenna lanes
   input  logic [AXNUM-1:0]      ax_data_i,
   output logic [AXNUM-1:0]      ax_data_o,
   // MCB command port
   output logic                  mcb_ce_o,
   output logic                  mcb_wr_o,
   output logic [MCB_ADDR_W-1:0] mcb_adr_o,
   output logic [MCB_DATA_W-1:0] mcb_dat_o,
   // Debug state
   output logic [2:0]            tart_state_o
);

   aq_ctrl_t         ctrl;
   mcb_cmd_t         mcb;
   aq_state_e        state;
   logic [AXNUM-1:0] buf_rd_dat;
   logic [IW-1:0]    wr_idx;
   logic [IW-1:0]    rd_idx;
   logic             wr_last;
   logic             rd_last;
   logic             buf_we;
   logic             wr_clr;
   logic             wr_step;
   logic             rd_clr;
   logic             rd_step;

   assign ctrl = '{aq_ce: aq_ce_i, aq_debug: aq_debug_i, rd_req: rd_req_i};

   // ----------------------------------------------------------
   // Capture path
   // ----------------------------------------------------------

   sample_capture #(
      .AXNUM (AXNUM)
   ) sample_capture_inst (
      .clk_e     (clk_e),
      .rst_i     (rst_i),
      .ctrl_i    (ctrl),
      .ax_data_i (ax_data_i),
      .ax_data_o (ax_data_o)
   );

   // One block of samples
   block_buffer #(
      .WIDTH (AXNUM),
      .DEPTH (BLOCK_LEN)
   ) block_buffer_inst (
      .clk_e    (clk_e),
      .we_i     (buf_we),
      .wr_adr_i (wr_idx),
      .wr_dat_i (ax_data_o),
      .rd_adr_i (rd_idx),
      .rd_dat_o (buf_rd_dat)
   );

   // ----------------------------------------------------------
   // Indices and sequencing
   // ----------------------------------------------------------

   // Capture index
   burst_counter #(
      .LEN (BLOCK_LEN)
   ) wr_counter_inst (
      .clk_e  (clk_e),
      .rst_i  (rst_i),
      .clr_i  (wr_clr),
      .step_i (wr_step),
      .idx_o  (wr_idx),
      .last_o (wr_last)
   );

   // Drain index
   burst_counter #(
      .LEN (BLOCK_LEN)
   ) rd_counter_inst (
      .clk_e  (clk_e),
      .rst_i  (rst_i),
      .clr_i  (rd_clr),
      .step_i (rd_step),
      .idx_o  (rd_idx),
      .last_o (rd_last)
   );

   aq_scheduler #(
      .AXNUM     (AXNUM),
      .BLOCK_LEN (BLOCK_LEN)
   ) aq_scheduler_inst (
      .clk_e     (clk_e),
      .rst_i     (rst_i),
      .ctrl_i    (ctrl),
      .wr_last_i (wr_last),
      .rd_last_i (rd_last),
      .rd_idx_i  (rd_idx),
      .rd_dat_i  (buf_rd_dat),
      .buf_we_o  (buf_we),
      .wr_clr_o  (wr_clr),
      .wr_step_o (wr_step),
      .rd_clr_o  (rd_clr),
      .rd_step_o (rd_step),
      .mcb_rdy_i (mcb_rdy_i),
      .mcb_o     (mcb),
      .state_o   (state)
   );

   // MCB fields onto pins
   assign mcb_ce_o     = mcb.ce;
   assign mcb_wr_o     = mcb.wr;
   assign mcb_adr_o    = mcb.adr;
   assign mcb_dat_o    = mcb.dat;
   assign tart_state_o = state;

endmodule

//--- logic/aq_scheduler.sv
`timescale 1ns/100ps

module aq_scheduler
   import capture_pkg::*, mcb_pkg::*;
#(
   parameter int  AXNUM     = 24,
   parameter int  BLOCK_LEN = 16,
   localparam int IW        = $clog2(BLOCK_LEN)
) (
   input  logic             clk_e,
   input  logic             rst_i,
   input  aq_ctrl_t         ctrl_i,
   // Counter status
   input  logic             wr_last_i,
   input  logic             rd_last_i,
   input  logic [IW-1:0]    rd_idx_i,
   // Buffered sample at the read index
   input  logic [AXNUM-1:0] rd_dat_i,
   // Buffer and counter control
   output logic             buf_we_o,
   output logic             wr_clr_o,
   output logic             wr_step_o,
   output logic             rd_clr_o,
   output logic             rd_step_o,
   // MCB command side
   input  logic             mcb_rdy_i,
   output mcb_cmd_t         mcb_o,
   output aq_state_e        state_o
);

   aq_state_e             state_q;
   aq_state_e             state_d;
   logic [MCB_ADDR_W-1:0] base_q;
   logic                  accept;

   // Word taken by the MCB this cycle
   assign accept = (state_q == WRITE) && mcb_rdy_i;

   // ----------------------------------------------------------
   // State sequencing
   // ----------------------------------------------------------

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (ctrl_i.aq_ce) begin
               state_d = CAPTURE;
            end
         end
         CAPTURE: begin
            // Leaves after the last sample is written
            if (wr_last_i) begin
               state_d = FETCH;
            end
         end
         FETCH: begin
            state_d = WRITE;
         end
         WRITE: begin
            if (mcb_rdy_i) begin
               state_d = rd_last_i ? DONE : FETCH;
            end
         end
         DONE: begin
            if (ctrl_i.rd_req) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_e) begin
      if (rst_i) begin
         state_q <= IDLE;
         base_q  <= '0;
      end else begin
         state_q <= state_d;
         // Next block goes right after this one
         if (accept && rd_last_i) begin
            base_q <= base_q + MCB_ADDR_W'(BLOCK_LEN);
         end
      end
   end

   assign state_o = state_q;

   // ----------------------------------------------------------
   // Buffer and counter steering
   // ----------------------------------------------------------

   assign buf_we_o  = (state_q == CAPTURE);
   assign wr_clr_o  = (state_q == IDLE);
   assign wr_step_o = (state_q == CAPTURE) && !wr_last_i;
   // Drain index starts at zero when the first fetch comes
   assign rd_clr_o  = (state_q == CAPTURE);
   assign rd_step_o = accept && !rd_last_i;

   // ----------------------------------------------------------
   // MCB command
   // ----------------------------------------------------------

   // Index and data only move on accept, so the command holds
   always_comb begin
      mcb_o.ce  = (state_q == WRITE);
      mcb_o.wr  = (state_q == WRITE);
      mcb_o.adr = base_q + MCB_ADDR_W'(rd_idx_i);
      mcb_o.dat = MCB_DATA_W'(rd_dat_i);
   end

   // Pending command, buffer read and index together stay put
   mcb_hold_a : assert property (
      @(posedge clk_e) disable iff (rst_i)
      mcb_o.ce && !mcb_rdy_i |=> $stable(mcb_o)
   );

endmodule

//--- logic/burst_counter.sv
`timescale 1ns/100ps

module burst_counter #(
   parameter int  LEN = 16,
   localparam int IW  = $clog2(LEN)
) (
   input  logic          clk_e,
   input  logic          rst_i,
   input  logic          clr_i,
   input  logic          step_i,
   output logic [IW-1:0] idx_o,
   output logic          last_o
);

   // ----------------------------------------------------------
   // Sequence index
   // ----------------------------------------------------------

   logic [IW-1:0] idx_q;

   always_ff @(posedge clk_e) begin
      if (rst_i) begin
         idx_q <= '0;
      end else if (clr_i) begin
         // Clear wins over step
         idx_q <= '0;
      end else if (step_i) begin
         idx_q <= idx_q + 1'b1;
      end
   end

   assign idx_o = idx_q;

   // Terminal index of the block
   assign last_o = (idx_q == IW'(LEN - 1));

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------

   // Scheduler must leave the burst on last, never wrap the index
   no_wrap_a : assert property (
      @(posedge clk_e) disable iff (rst_i)
      !(step_i && last_o && !clr_i)
   );

endmodule

//--- logic/block_buffer.sv
`timescale 1ns/100ps

module block_buffer #(
   parameter int  WIDTH = 24,
   parameter int  DEPTH = 16,
   localparam int AW    = $clog2(DEPTH)
) (
   input  logic             clk_e,
   input  logic             we_i,
   input  logic [AW-1:0]    wr_adr_i,
   input  logic [WIDTH-1:0] wr_dat_i,
   input  logic [AW-1:0]    rd_adr_i,
   output logic [WIDTH-1:0] rd_dat_o
);

   // ----------------------------------------------------------
   // Sample storage for one block
   // ----------------------------------------------------------

   logic [WIDTH-1:0] mem [DEPTH];

   // Write port
   always_ff @(posedge clk_e) begin
      if (we_i) begin
         mem[wr_adr_i] <= wr_dat_i;
      end
   end

   // Read port, data one cycle after address
   // Rereads every cycle, so a held address holds the data
   always_ff @(posedge clk_e) begin
      rd_dat_o <= mem[rd_adr_i];
   end

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------

   // Write index from the capture counter stays inside the block
   wr_range_a : assert property (
      @(posedge clk_e)
      we_i |-> (32'(wr_adr_i) < DEPTH)
   );

endmodule

//--- logic/sample_capture.sv
`timescale 1ns/100ps

module sample_capture
   import capture_pkg::*;
#(
   parameter int AXNUM = 24
) (
   input  logic             clk_e,
   input  logic             rst_i,
   input  aq_ctrl_t         ctrl_i,
   input  logic [AXNUM-1:0] ax_data_i,
   output logic [AXNUM-1:0] ax_data_o
);

   logic [AXNUM-1:0] ax_real;
   logic [AXNUM-1:0] ax_fake;
   logic [AXNUM-1:0] ax_mux;

   // ----------------------------------------------------------
   // Debug data source
   // ----------------------------------------------------------

   // Runs only while debug is selected
   fake_antenna #(
      .AXNUM (AXNUM)
   ) fake_antenna_inst (
      .clk_e  (clk_e),
      .rst_i  (rst_i),
      .en_i   (ctrl_i.aq_debug),
      .fake_o (ax_fake)
   );

   // ----------------------------------------------------------
   // Capture registers
   // ----------------------------------------------------------

   // Real or fake lanes
   assign ax_mux = ctrl_i.aq_debug ? ax_fake : ax_real;

   always_ff @(posedge clk_e) begin
      // Pin register, one per antenna
      ax_real   <= ax_data_i;
      // Output register feeds buffer and port
      ax_data_o <= ax_mux;
   end

endmodule

//--- logic/fake_antenna.sv
`timescale 1ns/100ps

module fake_antenna
   import capture_pkg::*;
#(
   parameter int AXNUM = 24
) (
   input  logic             clk_e,
   input  logic             rst_i,
   input  logic             en_i,
   output logic [AXNUM-1:0] fake_o
);

   // ----------------------------------------------------------
   // Pseudo-random antenna bits
   // ----------------------------------------------------------

   logic [LFSR_W-1:0] lfsr_q;
   logic              fb;

   // Taps 24, 23, 22, 17 give a maximal length sequence
   assign fb = lfsr_q[23] ^ lfsr_q[22] ^ lfsr_q[21] ^ lfsr_q[16];

   always_ff @(posedge clk_e) begin
      if (rst_i) begin
         // Nonzero seed
         lfsr_q <= LFSR_W'(1);
      end else if (en_i) begin
         // One step per enabled cycle
         lfsr_q <= {lfsr_q[LFSR_W-2:0], fb};
      end
   end

   // Low bits feed the antenna lanes
   assign fake_o = lfsr_q[AXNUM-1:0];

   // All-zero state would lock the generator up
   lfsr_nonzero_a : assert property (
      @(posedge clk_e) disable iff (rst_i)
      lfsr_q != '0
   );

endmodule

//--- logic/mcb_pkg.sv
package mcb_pkg;

   // ----------------------------------------------------------
   // Memory controller block bus
   // ----------------------------------------------------------

   // Word address width
   localparam int MCB_ADDR_W = 19;

   // Data word width
   localparam int MCB_DATA_W = 32;

   // One command as seen by the MCB
   typedef struct packed {
      // Command valid, held until ready
      logic                  ce;
      // Write flag
      logic                  wr;
      // Word address, wraps at the top of memory
      logic [MCB_ADDR_W-1:0] adr;
      // Write data, samples zero-extended
      logic [MCB_DATA_W-1:0] dat;
   } mcb_cmd_t;

endpackage

//--- logic/capture_pkg.sv
package capture_pkg;

   // ----------------------------------------------------------
   // Fake antenna source
   // ----------------------------------------------------------

   // LFSR register width, upper bound on antenna count
   localparam int LFSR_W = 24;

   // ----------------------------------------------------------
   // Acquisition sequencing
   // ----------------------------------------------------------

   // Scheduler states, also visible on the debug state port
   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      // Recording one block into the buffer
      CAPTURE = 3'd1,
      // Buffer read of one word
      FETCH   = 3'd2,
      // MCB command held until ready
      WRITE   = 3'd3,
      // Waiting on host read complete
      DONE    = 3'd4
   } aq_state_e;

   // Host control strobes
   typedef struct packed {
      // Start of block capture, single cycle
      logic aq_ce;
      // Fake source select, level
      logic aq_debug;
      // Host has read the block, single cycle
      logic rd_req;
   } aq_ctrl_t;

endpackage
